/* design/addr_calc.sv */
// Address stage: base plus index-times-stride for all loops, modulo 2^16.
// One cycle latency; addr_o holds its value while addr_valid_o is low.

module addr_calc (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  agu_pkg::loop_pos_t pos_i,
    input  logic               step_i,       // Capture strobe
    input  agu_pkg::agu_cfg_t  cfg_i,
    output agu_pkg::addr_t     addr_o,
    output logic               addr_valid_o
);
    import agu_pkg::*;

    addr_t addr_d;
    addr_t addr_q;
    logic  valid_q;

    // Multiply-add, all terms truncated to ADDR_W
    always_comb begin
        addr_t term;
        addr_d = cfg_i.base;
        for (int k = 0; k < N_LOOPS; k++) begin
            term   = ADDR_W'(pos_i.idx[k]) * cfg_i.stride[k]; // Low half of product
            addr_d = addr_d + term;                           // Wraps mod 2^16
        end
    end

    // Address payload, updated only on a step
    always_ff @(posedge clk_i) begin
        if (step_i) begin
            addr_q <= addr_d;
        end
    end

    // Valid is step delayed by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= step_i;
        end
    end

    assign addr_o       = addr_q;
    assign addr_valid_o = valid_q;

endmodule

/* design/agu_cfg_regs.sv */
// Configuration register block of the address generator.
// Writes land on the clock edge with we_i high unless a run is in progress.
// Readback is a combinational mux on addr_i.

module agu_cfg_regs (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               we_i,     // Write strobe
    input  agu_pkg::reg_addr_e addr_i,   // Shared by write and readback
    input  agu_pkg::addr_t     wdata_i,
    input  logic               busy_i,   // Locks the registers during a run
    output agu_pkg::addr_t     rdata_o,
    output agu_pkg::agu_cfg_t  cfg_o
);
    import agu_pkg::*;

    agu_cfg_t cfg_q;
    logic     wr_en;

    assign wr_en = we_i && !busy_i; // Writes while busy are dropped
    assign cfg_o = cfg_q;

    // Write decode
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (addr_i)
                REG_BASE: begin
                    cfg_q.base <= wdata_i;
                end
                REG_BOUND0: begin
                    cfg_q.bound[0] <= wdata_i[LOOP_W-1:0]; // Upper bits dropped
                end
                REG_BOUND1: begin
                    cfg_q.bound[1] <= wdata_i[LOOP_W-1:0];
                end
                REG_BOUND2: begin
                    cfg_q.bound[2] <= wdata_i[LOOP_W-1:0];
                end
                REG_STRIDE0: begin
                    cfg_q.stride[0] <= wdata_i;
                end
                REG_STRIDE1: begin
                    cfg_q.stride[1] <= wdata_i;
                end
                REG_STRIDE2: begin
                    cfg_q.stride[2] <= wdata_i;
                end
                REG_DIR: begin
                    cfg_q.dir <= wdata_i[N_LOOPS-1:0]; // One bit per loop
                end
                default: begin
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    // Readback mux, narrow fields zero-extended
    always_comb begin
        rdata_o = '0;
        case (addr_i)
            REG_BASE:    rdata_o = cfg_q.base;
            REG_BOUND0:  rdata_o = ADDR_W'(cfg_q.bound[0]);
            REG_BOUND1:  rdata_o = ADDR_W'(cfg_q.bound[1]);
            REG_BOUND2:  rdata_o = ADDR_W'(cfg_q.bound[2]);
            REG_STRIDE0: rdata_o = cfg_q.stride[0];
            REG_STRIDE1: rdata_o = cfg_q.stride[1];
            REG_STRIDE2: rdata_o = cfg_q.stride[2];
            REG_DIR:     rdata_o = ADDR_W'(cfg_q.dir);
            default:     rdata_o = '0;
        endcase
    end

endmodule

/* design/agu_pkg.sv */
// Shared types and constants for the three-level loop address generator.
// Import into module bodies; use scoped names in port lists.

package agu_pkg;

    localparam int unsigned LOOP_W     = 8;  // Loop index and bound width
    localparam int unsigned ADDR_W     = 16; // Base, stride and address width
    localparam int unsigned N_LOOPS    = 3;  // Index 0 is inner, 2 is outer
    localparam int unsigned REG_ADDR_W = 3;  // Register address width

    typedef logic [LOOP_W-1:0] loop_idx_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Register map for the config block
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_BASE    = 3'd0,
        REG_BOUND0  = 3'd1,
        REG_BOUND1  = 3'd2,
        REG_BOUND2  = 3'd3,
        REG_STRIDE0 = 3'd4,
        REG_STRIDE1 = 3'd5,
        REG_STRIDE2 = 3'd6,
        REG_DIR     = 3'd7
    } reg_addr_e;

    // Loop controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD, // One cycle, counters take start values
        ST_RUN,
        ST_DONE  // Completion cycle, counters cleared
    } agu_state_e;

    // Full configuration as seen by controller and address stage
    typedef struct packed {
        addr_t                     base;
        loop_idx_t [N_LOOPS-1:0]   bound;  // Loop k runs bound[k]+1 steps
        addr_t     [N_LOOPS-1:0]   stride;
        logic      [N_LOOPS-1:0]   dir;    // 1 counts down from bound to 0
    } agu_cfg_t;

    // Current position in the loop nest
    typedef struct packed {
        loop_idx_t [N_LOOPS-1:0] idx;
    } loop_pos_t;

endpackage

/* design/agu_top.sv */
// Top level of the three-level loop address generator.
// Software programs the registers, pulses start_i and collects one address
// per addr_valid_o; done_o marks the final address of the run.

module agu_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               cfg_we_i,     // Register write strobe
    input  agu_pkg::reg_addr_e cfg_addr_i,   // Write and readback address
    input  agu_pkg::addr_t     cfg_wdata_i,
    output agu_pkg::addr_t     cfg_rdata_o,  // Combinational readback
    input  logic               start_i,      // Pulse, taken in idle only
    input  logic               stall_i,      // Hold the walk
    output agu_pkg::addr_t     addr_o,
    output logic               addr_valid_o,
    output logic               busy_o,
    output logic               done_o
);
    import agu_pkg::*;

    agu_cfg_t  cfg;  // Register contents to controller and address stage
    loop_pos_t pos;  // Current loop indices
    logic      step; // One address per step

    // Registers, locked while the controller is busy
    agu_cfg_regs u_regs (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (cfg_we_i),
        .addr_i  (cfg_addr_i),
        .wdata_i (cfg_wdata_i),
        .busy_i  (busy_o),
        .rdata_o (cfg_rdata_o),
        .cfg_o   (cfg)
    );

    loop_nest_ctrl u_ctrl (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (start_i),
        .stall_i (stall_i),
        .cfg_i   (cfg),
        .pos_o   (pos),
        .step_o  (step),
        .busy_o  (busy_o),
        .done_o  (done_o)
    );

    // Registered address output
    addr_calc u_addr (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pos_i        (pos),
        .step_i       (step),
        .cfg_i        (cfg),
        .addr_o       (addr_o),
        .addr_valid_o (addr_valid_o)
    );

endmodule

/* design/loop_nest_ctrl.sv */
// Loop nest controller: FSM plus one counter per loop.
// A start pulse in idle loads the counters, then each unstalled run cycle
// issues one step; the step where all loops show last ends the run.

module loop_nest_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              start_i,  // One-cycle pulse, idle only
    input  logic              stall_i,  // Level, freezes the walk
    input  agu_pkg::agu_cfg_t cfg_i,
    output agu_pkg::loop_pos_t pos_o,
    output logic              step_o,   // One address per step
    output logic              busy_o,
    output logic              done_o
);
    import agu_pkg::*;

    agu_state_e state_q;
    agu_state_e state_d;

    loop_idx_t          cnt_q     [N_LOOPS]; // Counter outputs
    loop_idx_t          start_val [N_LOOPS]; // Load values by direction
    logic [N_LOOPS-1:0] last;
    logic [N_LOOPS:0]   carry;               // carry[k] enables loop k
    logic               cnt_load;
    logic               cnt_clear;
    logic               step;
    logic               finish;

    assign step      = (state_q == ST_RUN) && !stall_i;
    assign cnt_load  = (state_q == ST_LOAD);
    assign cnt_clear = (state_q == ST_DONE);

    // Inner loop steps every time, outer ones when all inner show last
    assign carry[0] = step;
    assign finish   = carry[N_LOOPS]; // Final step of the nest

    for (genvar k = 0; k < N_LOOPS; k++) begin : g_loop
        assign start_val[k] = cfg_i.dir[k] ? cfg_i.bound[k] : '0; // Down loops begin at bound
        assign carry[k+1]   = carry[k] & last[k];

        programmable_counter u_cnt (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .clear_i (cnt_clear),
            .en_i    (carry[k]),
            .load_i  (cnt_load),
            .down_i  (cfg_i.dir[k]),
            .bound_i (cfg_i.bound[k]),
            .d_i     (start_val[k]),
            .q_o     (cnt_q[k]),
            .last_o  (last[k])
        );
    end

    always_comb begin
        for (int k = 0; k < N_LOOPS; k++) begin
            pos_o.idx[k] = cnt_q[k];
        end
    end

    // FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_LOAD;
                end
            end
            ST_LOAD: state_d = ST_RUN; // Counters load at this edge
            ST_RUN: begin
                if (finish) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign step_o = step;
    assign busy_o = (state_q != ST_IDLE);  // LOAD through DONE
    assign done_o = (state_q == ST_DONE);  // Lines up with last addr_valid

endmodule

/* design/programmable_counter.sv */
// Loadable up/down counter with a runtime bound.
// last_o flags the final value of a sweep: bound when counting up, 0 when down.

module programmable_counter (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i, // Highest priority, forces 0
    input  logic               en_i,    // Take one step
    input  logic               load_i,  // Load d_i, beats en_i
    input  logic               down_i,  // 1 counts down
    input  agu_pkg::loop_idx_t bound_i, // Top of the count range
    input  agu_pkg::loop_idx_t d_i,     // Load value
    output agu_pkg::loop_idx_t q_o,
    output logic               last_o
);
    import agu_pkg::*;

    loop_idx_t cnt_q;
    loop_idx_t cnt_d;
    logic      at_top;
    logic      at_zero;

    assign at_top  = (cnt_q == bound_i);
    assign at_zero = (cnt_q == '0);

    assign q_o    = cnt_q;
    assign last_o = down_i ? at_zero : at_top; // Depends on current direction

    // Next value
    always_comb begin
        cnt_d = cnt_q;
        if (clear_i) begin
            cnt_d = '0;
        end else if (load_i) begin
            cnt_d = d_i;
        end else if (en_i) begin
            if (down_i) begin
                // Wrap back up to the bound below 0
                if (at_zero) begin
                    cnt_d = bound_i;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end else begin
                if (at_top) begin
                    cnt_d = '0; // Restart sweep
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

endmodule

/* files.f */
design/agu_pkg.sv
design/programmable_counter.sv
design/agu_cfg_regs.sv
design/loop_nest_ctrl.sv
design/addr_calc.sv
design/agu_top.sv
verif/tb_clk_gen.sv
verif/agu_checker.sv
verif/agu_tb.sv

/* verif/agu_checker.sv */
// Concurrent assertions on the control outputs of the address generator.
// Attached to agu_top by the bind below; fail_cnt counts failed assertions.

module agu_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic stall_i,
    input logic busy_i,
    input logic done_i,
    input logic valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;

    // Completion is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_i |=> !done_i)
    else begin
        $error("done_o stayed high for more than one cycle");
        fail_cnt++;
    end

    // Final address and done share a cycle
    a_done_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_i |-> valid_i)
    else begin
        $error("done_o without addr_valid_o");
        fail_cnt++;
    end

    // A valid address needs a busy controller one cycle earlier
    a_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> $past(busy_i))
    else begin
        $error("addr_valid_o high without busy_o in the cycle before");
        fail_cnt++;
    end

    a_valid_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> !$past(stall_i)) // Stalled cycle issues no step
    else begin
        $error("addr_valid_o high right after a stalled cycle");
        fail_cnt++;
    end

    // Outputs quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> (!busy_i && !done_i && !valid_i))
    else begin
        $error("Control outputs active during reset");
        fail_cnt++;
    end

endmodule

bind agu_top agu_checker u_chk (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall_i (stall_i),
    .busy_i  (busy_o),
    .done_i  (done_o),
    .valid_i (addr_valid_o)
);

/* verif/agu_tb.sv */
// Directed testbench for the loop address generator.
// Programs the registers, runs walks with and without stall and compares
// every address with a software model of the loop nest.

module agu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import agu_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      cfg_we;
    reg_addr_e cfg_addr;
    addr_t     cfg_wdata;
    addr_t     cfg_rdata;
    logic      start;
    logic      stall;
    addr_t     addr;
    logic      addr_valid;
    logic      busy;
    logic      done;

    agu_cfg_t    cfg_m;            // Model copy of the programmed registers
    addr_t       exp_q [$];        // Expected address list
    logic [31:0] rng_state;
    int          first_valid_edge; // Edges from start drive to first valid
    int          got_count;        // Addresses collected in the last walk

    tb_clk_gen u_clk (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    agu_top uut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata),
        .start_i      (start),
        .stall_i      (stall),
        .addr_o       (addr),
        .addr_valid_o (addr_valid),
        .busy_o       (busy),
        .done_o       (done)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_addr(input int idx, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %0d ns: addr_o[%0d] got %h expected %h",
                                    $time, idx, got, exp));
        end
    endtask

    task automatic check_reg(input reg_addr_e a, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %0d ns: cfg_rdata_o (%s) got %h expected %h",
                                    $time, a.name(), got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %0d ns: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("Error: %0d ns: %s got %0d expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Model: inner loop fastest, down loops sweep bound..0
    function automatic void build_expected();
        int unsigned sum;
        int unsigned idx [N_LOOPS];
        exp_q.delete();
        for (int n2 = 0; n2 <= int'(cfg_m.bound[2]); n2++) begin
            for (int n1 = 0; n1 <= int'(cfg_m.bound[1]); n1++) begin
                for (int n0 = 0; n0 <= int'(cfg_m.bound[0]); n0++) begin
                    idx[0] = cfg_m.dir[0] ? cfg_m.bound[0] - n0 : n0;
                    idx[1] = cfg_m.dir[1] ? cfg_m.bound[1] - n1 : n1;
                    idx[2] = cfg_m.dir[2] ? cfg_m.bound[2] - n2 : n2;
                    sum = cfg_m.base + idx[0] * cfg_m.stride[0]
                        + idx[1] * cfg_m.stride[1] + idx[2] * cfg_m.stride[2];
                    exp_q.push_back(addr_t'(sum)); // Modulo 2^16
                end
            end
        end
    endfunction

    task automatic write_reg(input reg_addr_e a, input addr_t d);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic read_check(input reg_addr_e a, input addr_t exp);
        @(negedge clk);
        cfg_addr = a;
        #1;                          // Readback mux settles
        check_reg(a, cfg_rdata, exp);
    endtask

    task automatic program_cfg(input agu_cfg_t c);
        cfg_m = c;
        write_reg(REG_BASE, c.base);
        for (int k = 0; k < N_LOOPS; k++) begin
            write_reg(reg_addr_e'(int'(REG_BOUND0) + k), {8'hA5, c.bound[k]}); // Junk upper byte
            write_reg(reg_addr_e'(int'(REG_STRIDE0) + k), c.stride[k]);
        end
        write_reg(REG_DIR, addr_t'(c.dir));
    endtask

    task automatic random_cfg(output agu_cfg_t c);
        logic [31:0] r;
        c = '0;
        r = next_rand();
        c.base = r[15:0];
        c.dir  = r[18:16];
        for (int k = 0; k < N_LOOPS; k++) begin
            r = next_rand();
            c.bound[k]  = loop_idx_t'(r[1:0]); // Small bounds, short runs
            c.stride[k] = r[31:16];
        end
    endtask

    task automatic wait_busy(input logic lvl, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== lvl) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                stop_on_error($sformatf("Timeout waiting for busy_o to go %b %s", lvl, what));
            end
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b0) begin
            #1;
            n++;
            if (n > 20) stop_on_error("Timeout waiting for reset to be asserted");
        end
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 50) stop_on_error("Timeout waiting for reset to be released");
        end
    endtask

    // One full walk from a start pulse to done_o, checked address by address
    task automatic run_walk(input bit use_stall, input bit poke_start);
        int n_edges;
        int n_got;
        int limit;
        bit seen_done;
        build_expected();
        limit = exp_q.size() * 8 + 40;
        n_edges = 0;
        n_got = 0;
        seen_done = 1'b0;
        first_valid_edge = -1;
        @(negedge clk);
        stall = 1'b0;
        start = 1'b1;
        while (!seen_done) begin
            @(negedge clk);
            start = 1'b0;
            n_edges++;
            if (n_edges > limit) stop_on_error("Timeout waiting for done_o at the end of a walk");
            check_flag("busy_o during a walk", busy, 1'b1); // LOAD through DONE
            if (addr_valid) begin
                // stall still holds the value of the cycle that just ended
                if (stall) stop_on_error("addr_valid_o appeared right after a stalled cycle");
                if (n_got >= exp_q.size()) stop_on_error("More addresses than the bounds allow");
                if (first_valid_edge < 0) first_valid_edge = n_edges;
                check_addr(n_got, addr, exp_q[n_got]);
                n_got++;
            end
            if (done) begin
                check_flag("addr_valid_o with done_o", addr_valid, 1'b1);
                seen_done = 1'b1;
            end
            if (poke_start && n_edges == 4) start = 1'b1; // Mid-run, must be ignored
            stall = (use_stall && !seen_done) ? (next_rand() % 3 == 0) : 1'b0;
        end
        check_count("address count", n_got, exp_q.size());
        got_count = n_got;
    endtask

    task automatic reset_and_regs();
        check_flag("busy_o", busy, 1'b0);
        check_flag("done_o", done, 1'b0);
        check_flag("addr_valid_o", addr_valid, 1'b0);
        for (int k = 0; k < 8; k++) begin
            read_check(reg_addr_e'(k), '0);
        end
        write_reg(REG_BASE, 16'hBEEF);
        write_reg(REG_BOUND0, 16'h1203); // Upper byte dropped
        write_reg(REG_BOUND1, 16'hFF02);
        write_reg(REG_BOUND2, 16'h0001);
        write_reg(REG_STRIDE0, 16'h0004);
        write_reg(REG_STRIDE1, 16'h0040);
        write_reg(REG_STRIDE2, 16'h0400);
        write_reg(REG_DIR, 16'hFFF5);    // Only 3 bits kept
        read_check(REG_BASE, 16'hBEEF);
        read_check(REG_BOUND0, 16'h0003);
        read_check(REG_BOUND1, 16'h0002);
        read_check(REG_BOUND2, 16'h0001);
        read_check(REG_STRIDE0, 16'h0004);
        read_check(REG_STRIDE1, 16'h0040);
        read_check(REG_STRIDE2, 16'h0400);
        read_check(REG_DIR, 16'h0005);
        // Writes while a run is in progress
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_busy(1'b1, 10, "after start");
        write_reg(REG_BASE, 16'h1111);
        write_reg(REG_BOUND0, 16'h0007);
        read_check(REG_BASE, 16'hBEEF);
        read_check(REG_BOUND0, 16'h0003);
        wait_busy(1'b0, 200, "at the end of the run");
        read_check(REG_BASE, 16'hBEEF);
    endtask

    task automatic up_walk();
        agu_cfg_t c;
        c = '0;
        c.base   = 16'h1000;
        c.bound  = {8'd1, 8'd2, 8'd3};           // Outer to inner
        c.stride = {16'h0100, 16'h0010, 16'h0001};
        program_cfg(c);
        run_walk(1'b0, 1'b0);
        check_count("up walk length", got_count, 24);
    endtask

    task automatic mixed_dirs();
        agu_cfg_t c;
        c = '0;
        c.base   = 16'h2000;
        c.bound  = {8'd1, 8'd3, 8'd2};
        c.stride = {16'h0200, 16'h0020, 16'h0002};
        c.dir    = 3'b011;                       // Inner and middle count down
        program_cfg(c);
        run_walk(1'b0, 1'b0);
        c.dir = 3'b100;
        program_cfg(c);
        run_walk(1'b0, 1'b0);
    endtask

    task automatic stall_walk();
        agu_cfg_t c;
        c = '0;
        c.base   = 16'hFFF0;                     // Sums wrap past 2^16
        c.bound  = {8'd2, 8'd2, 8'd4};
        c.stride = {16'h8001, 16'h1234, 16'h0003};
        c.dir    = 3'b010;
        program_cfg(c);
        run_walk(1'b1, 1'b0);
        run_walk(1'b0, 1'b0);                    // Same list without stall
    endtask

    task automatic timing_and_restart();
        agu_cfg_t c;
        c = '0;
        c.base   = 16'h0400;
        c.bound  = {8'd1, 8'd1, 8'd3};
        c.stride = {16'h0040, 16'h0008, 16'h0001};
        program_cfg(c);
        run_walk(1'b0, 1'b1);
        check_count("edges from start to first addr_valid_o", first_valid_edge, 3);
        repeat (3) begin
            @(negedge clk);
            check_flag("busy_o after done", busy, 1'b0); // Mid-run start left no trace
        end
        run_walk(1'b0, 1'b0);
        check_count("edges from restart to first addr_valid_o", first_valid_edge, 3);
        for (int n = 0; n < 6; n++) begin
            random_cfg(c);
            program_cfg(c);
            run_walk(n[0], 1'b0); // Odd runs stalled
        end
    endtask

    initial begin
        cfg_we    = 1'b0;
        cfg_addr  = REG_BASE;
        cfg_wdata = '0;
        start     = 1'b0;
        stall     = 1'b0;
        rng_state = 32'h06ebf0ef;
        wait_reset_release();
        reset_and_regs();
        up_walk();
        mixed_dirs();
        stall_walk();
        timing_and_restart();
        repeat (2) @(negedge clk);
        if (uut.u_chk.fail_cnt != 0) begin
            stop_on_error($sformatf("Checker reported %0d assertion failures",
                                    uut.u_chk.fail_cnt));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* verif/tb_clk_gen.sv */
// Clock and reset source for the address generator testbench.
// 10 ns clock; reset goes low just after time 0 and is held for 10 cycles.

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // 10 ns period
    end

    initial begin
        rst_no = 1'b1;
        #1 rst_no = 1'b0;              // Clean falling edge for the async reset
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;                 // Release away from the active edge
    end

endmodule
